// ==== src/cpu_types_pkg.sv ====
`default_nettype none

package cpu_types_pkg;

    // datapath widths
    parameter int WORD_W     = 32;
    parameter int REG_ADDR_W = 5;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        RTYPE = 6'b000000,
        J     = 6'b000010,
        JAL   = 6'b000011,
        BEQ   = 6'b000100,
        BNE   = 6'b000101,
        ADDI  = 6'b001000,
        ADDIU = 6'b001001,
        SLTI  = 6'b001010,
        ANDI  = 6'b001100,
        ORI   = 6'b001101,
        XORI  = 6'b001110,
        LUI   = 6'b001111,
        LW    = 6'b100011,
        SW    = 6'b101011,
        HALT  = 6'b111111
    } opcode_t;

    // r-type function field, instr[5:0]
    typedef enum logic [5:0] {
        ALU_SLL  = 6'b000000,
        ALU_SRL  = 6'b000010,
        JR       = 6'b001000,
        ALU_ADD  = 6'b100000,
        ALU_ADDU = 6'b100001,
        ALU_SUB  = 6'b100010,
        ALU_SUBU = 6'b100011,
        ALU_AND  = 6'b100100,
        ALU_OR   = 6'b100101,
        ALU_XOR  = 6'b100110,
        ALU_NOR  = 6'b100111,
        ALU_SLT  = 6'b101010,
        ALU_SLTU = 6'b101011
    } funct_t;

    // operations the alu understands
    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_LUI
    } aluop_t;

    typedef enum logic [1:0] {
        FETCH, EXECUTE, MEMORY, HALTED
    } seq_state_t;

endpackage

`default_nettype wire

// ==== src/control_unit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface control_unit_if;

    logic [cpu_types_pkg::WORD_W-1:0]     instr;
    // register fields split out of the instruction word
    logic [cpu_types_pkg::REG_ADDR_W-1:0] rs;
    logic [cpu_types_pkg::REG_ADDR_W-1:0] rt;
    logic [cpu_types_pkg::REG_ADDR_W-1:0] rd;

    cpu_types_pkg::aluop_t alu_op;
    logic alu_src_imm, imm_zero_ext, reg_dst_rd, link, reg_write;
    logic mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg, halt;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    modport cu (
        input  instr,
        output alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, link, reg_write,
        output mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg, halt
    );

    modport dp (
        output instr,
        input  rs, rt, rd,
        input  alu_op, alu_src_imm, imm_zero_ext, reg_dst_rd, link, reg_write,
        input  mem_read, mem_write, branch_eq, branch_ne, jump, jump_reg, halt
    );

endinterface

`default_nettype wire

// ==== src/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    control_unit_if.cu cuif
);

    cpu_types_pkg::opcode_t opcode;
    cpu_types_pkg::funct_t  funct;

    assign opcode = cpu_types_pkg::opcode_t'(cuif.instr[cpu_types_pkg::WORD_W-1 -: 6]);
    assign funct  = cpu_types_pkg::funct_t'(cuif.instr[5:0]);

    always_comb begin
        // everything inactive unless decoded below, so unknown codes are no-ops
        cuif.alu_op       = cpu_types_pkg::OP_ADD;
        cuif.alu_src_imm  = 1'b0;
        cuif.imm_zero_ext = 1'b0;
        cuif.reg_dst_rd   = 1'b0;
        cuif.link         = 1'b0;
        cuif.reg_write    = 1'b0;
        cuif.mem_read     = 1'b0;
        cuif.mem_write    = 1'b0;
        cuif.branch_eq    = 1'b0;
        cuif.branch_ne    = 1'b0;
        cuif.jump         = 1'b0;
        cuif.jump_reg     = 1'b0;
        cuif.halt         = 1'b0;

        case (opcode)
            cpu_types_pkg::RTYPE: begin
                cuif.reg_dst_rd = 1'b1;
                cuif.reg_write  = 1'b1;
                case (funct)
                    cpu_types_pkg::ALU_ADD,
                    cpu_types_pkg::ALU_ADDU: cuif.alu_op = cpu_types_pkg::OP_ADD;
                    cpu_types_pkg::ALU_SUB,
                    cpu_types_pkg::ALU_SUBU: cuif.alu_op = cpu_types_pkg::OP_SUB;
                    cpu_types_pkg::ALU_AND:  cuif.alu_op = cpu_types_pkg::OP_AND;
                    cpu_types_pkg::ALU_OR:   cuif.alu_op = cpu_types_pkg::OP_OR;
                    cpu_types_pkg::ALU_XOR:  cuif.alu_op = cpu_types_pkg::OP_XOR;
                    cpu_types_pkg::ALU_NOR:  cuif.alu_op = cpu_types_pkg::OP_NOR;
                    cpu_types_pkg::ALU_SLT:  cuif.alu_op = cpu_types_pkg::OP_SLT;
                    cpu_types_pkg::ALU_SLTU: cuif.alu_op = cpu_types_pkg::OP_SLTU;
                    cpu_types_pkg::ALU_SLL:  cuif.alu_op = cpu_types_pkg::OP_SLL;
                    cpu_types_pkg::ALU_SRL:  cuif.alu_op = cpu_types_pkg::OP_SRL;
                    cpu_types_pkg::JR: begin
                        cuif.reg_write = 1'b0;
                        cuif.jump_reg  = 1'b1;
                    end
                    default: begin
                        cuif.reg_dst_rd = 1'b0;
                        cuif.reg_write  = 1'b0;
                    end
                endcase
            end
            cpu_types_pkg::J: cuif.jump = 1'b1;
            cpu_types_pkg::JAL: begin
                cuif.jump      = 1'b1;
                cuif.link      = 1'b1;
                cuif.reg_write = 1'b1;
            end
            // compare by subtraction, decided on the zero flag
            cpu_types_pkg::BEQ: begin
                cuif.alu_op    = cpu_types_pkg::OP_SUB;
                cuif.branch_eq = 1'b1;
            end
            cpu_types_pkg::BNE: begin
                cuif.alu_op    = cpu_types_pkg::OP_SUB;
                cuif.branch_ne = 1'b1;
            end
            cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU: begin
                cuif.alu_src_imm = 1'b1;
                cuif.reg_write   = 1'b1;
            end
            cpu_types_pkg::SLTI: begin
                cuif.alu_op      = cpu_types_pkg::OP_SLT;
                cuif.alu_src_imm = 1'b1;
                cuif.reg_write   = 1'b1;
            end
            cpu_types_pkg::ANDI, cpu_types_pkg::ORI, cpu_types_pkg::XORI,
            cpu_types_pkg::LUI: begin
                cuif.alu_src_imm  = 1'b1;
                cuif.imm_zero_ext = 1'b1;
                cuif.reg_write    = 1'b1;
                case (opcode)
                    cpu_types_pkg::ANDI: cuif.alu_op = cpu_types_pkg::OP_AND;
                    cpu_types_pkg::ORI:  cuif.alu_op = cpu_types_pkg::OP_OR;
                    cpu_types_pkg::XORI: cuif.alu_op = cpu_types_pkg::OP_XOR;
                    default:             cuif.alu_op = cpu_types_pkg::OP_LUI;
                endcase
            end
            // address is rs plus the sign-extended offset
            cpu_types_pkg::LW: begin
                cuif.alu_src_imm = 1'b1;
                cuif.reg_write   = 1'b1;
                cuif.mem_read    = 1'b1;
            end
            cpu_types_pkg::SW: begin
                cuif.alu_src_imm = 1'b1;
                cuif.mem_write   = 1'b1;
            end
            cpu_types_pkg::HALT: cuif.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [cpu_types_pkg::WORD_W-1:0] a,
    input  logic [cpu_types_pkg::WORD_W-1:0] b,
    input  logic [4:0]                       shamt,
    input  cpu_types_pkg::aluop_t            op,
    output logic [cpu_types_pkg::WORD_W-1:0] result,
    output logic                             zero
);

    always_comb begin
        case (op)
            cpu_types_pkg::OP_ADD:  result = a + b;
            cpu_types_pkg::OP_SUB:  result = a - b;
            cpu_types_pkg::OP_AND:  result = a & b;
            cpu_types_pkg::OP_OR:   result = a | b;
            cpu_types_pkg::OP_XOR:  result = a ^ b;
            cpu_types_pkg::OP_NOR:  result = ~(a | b);
            cpu_types_pkg::OP_SLT: begin
                result = {{(cpu_types_pkg::WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            end
            cpu_types_pkg::OP_SLTU: begin
                result = {{(cpu_types_pkg::WORD_W-1){1'b0}}, a < b};
            end
            // shifts act on the rt operand
            cpu_types_pkg::OP_SLL:  result = b << shamt;
            cpu_types_pkg::OP_SRL:  result = b >> shamt;
            cpu_types_pkg::OP_LUI:  result = {b[15:0], 16'h0000};
            default:                result = '0;
        endcase
    end

    // used for beq / bne after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                 CLK,
    input  logic                                 arst_n,
    input  logic [cpu_types_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [cpu_types_pkg::REG_ADDR_W-1:0] rt_addr,
    input  logic [cpu_types_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic                                 wr_en,
    input  logic [cpu_types_pkg::WORD_W-1:0]     wr_data,
    output logic [cpu_types_pkg::WORD_W-1:0]     rs_data,
    output logic [cpu_types_pkg::WORD_W-1:0]     rt_data
);

    localparam int NUM_REGS = 2 ** cpu_types_pkg::REG_ADDR_W;

    logic [cpu_types_pkg::WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // r0 never written so it always reads back 0
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// ==== src/core_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_datapath #(
    parameter logic [cpu_types_pkg::WORD_W-1:0] RESET_PC   = '0,
    parameter int                               ADDR_WIDTH = 16
) (
    input  logic                             CLK,
    input  logic                             arst_n,
    control_unit_if.dp                       cuif,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ADDR_WIDTH-1:0]            wb_adr,
    output logic [cpu_types_pkg::WORD_W-1:0] wb_dat_w,
    input  logic [cpu_types_pkg::WORD_W-1:0] wb_dat_r,
    input  logic                             wb_ack,
    output logic                             halt
);

    localparam int W = cpu_types_pkg::WORD_W;

    cpu_types_pkg::seq_state_t state;

    logic [W-1:0] pc, ir, pc_plus4, next_pc;
    logic [W-1:0] imm_sext, imm_zext, alu_b, alu_result;
    logic [W-1:0] rs_data, rt_data, wr_data;
    logic [W-1:0] branch_target, jump_target;
    logic [cpu_types_pkg::REG_ADDR_W-1:0] wr_addr;
    logic alu_zero, branch_taken, mem_access, wr_en;

    assign cuif.instr = ir;

    // operand selection
    assign imm_sext = {{(W-16){ir[15]}}, ir[15:0]};
    assign imm_zext = {{(W-16){1'b0}}, ir[15:0]};
    assign alu_b    = !cuif.alu_src_imm ? rt_data :
                      cuif.imm_zero_ext ? imm_zext : imm_sext;

    alu u_alu (
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (ir[10:6]),
        .op     (cuif.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // next pc
    assign pc_plus4      = pc + W'(4);
    assign branch_target = pc_plus4 + {imm_sext[W-3:0], 2'b00};
    assign jump_target   = {pc_plus4[W-1:28], ir[25:0], 2'b00};
    assign branch_taken  = (cuif.branch_eq && alu_zero) || (cuif.branch_ne && !alu_zero);
    assign next_pc       = cuif.jump_reg ? rs_data :
                           cuif.jump     ? jump_target :
                           branch_taken  ? branch_target : pc_plus4;

    assign mem_access = cuif.mem_read || cuif.mem_write;

    // write-back, loads only once the data phase is acked
    assign wr_en = ((state == cpu_types_pkg::EXECUTE) && cuif.reg_write && !cuif.mem_read) ||
                   ((state == cpu_types_pkg::MEMORY) && cuif.mem_read && wb_ack);
    assign wr_addr = cuif.link       ? cpu_types_pkg::REG_ADDR_W'(31) :
                     cuif.reg_dst_rd ? cuif.rd : cuif.rt;
    assign wr_data = (state == cpu_types_pkg::MEMORY) ? wb_dat_r :
                     cuif.link ? pc_plus4 : alu_result;

    register_file u_register_file (
        .CLK     (CLK),
        .arst_n  (arst_n),
        .rs_addr (cuif.rs),
        .rt_addr (cuif.rt),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state  <= cpu_types_pkg::FETCH;
            pc     <= RESET_PC;
            ir     <= '0;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (state)
                cpu_types_pkg::FETCH: begin
                    if (!wb_cyc) begin
                        // idle after reset or after a data cycle
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        ir     <= wb_dat_r;
                        state  <= cpu_types_pkg::EXECUTE;
                    end
                end
                cpu_types_pkg::EXECUTE: begin
                    if (cuif.halt) begin
                        state <= cpu_types_pkg::HALTED;
                    end else if (mem_access) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= cuif.mem_write;
                        state  <= cpu_types_pkg::MEMORY;
                    end else begin
                        // start the next fetch right away
                        pc     <= next_pc;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        state  <= cpu_types_pkg::FETCH;
                    end
                end
                cpu_types_pkg::MEMORY: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        pc     <= pc_plus4;
                        state  <= cpu_types_pkg::FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    // address and write data, loaded only when a cycle starts
    always_ff @(posedge CLK) begin
        if ((state == cpu_types_pkg::FETCH) && !wb_cyc) begin
            wb_adr <= pc[ADDR_WIDTH-1:0];
        end else if (state == cpu_types_pkg::EXECUTE) begin
            wb_adr   <= mem_access ? alu_result[ADDR_WIDTH-1:0] : next_pc[ADDR_WIDTH-1:0];
            wb_dat_w <= rt_data;
        end
    end

    assign halt = (state == cpu_types_pkg::HALTED);

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [cpu_types_pkg::WORD_W-1:0] RESET_PC   = '0,
    parameter int                               ADDR_WIDTH = 16
) (
    input  logic                             CLK,
    input  logic                             arst_n,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ADDR_WIDTH-1:0]            wb_adr,
    output logic [cpu_types_pkg::WORD_W-1:0] wb_dat_w,
    input  logic [cpu_types_pkg::WORD_W-1:0] wb_dat_r,
    input  logic                             wb_ack,
    output logic                             halt
);

    control_unit_if cuif ();

    control_unit u_control_unit (
        .cuif (cuif.cu)
    );

    core_datapath #(
        .RESET_PC   (RESET_PC),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_core_datapath (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .cuif     (cuif.dp),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .halt     (halt)
    );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic arst_n
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // released on a rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/mips_core_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_properties #(
    parameter int ADDR_WIDTH = 16
) (
    input logic                      CLK,
    input logic                      arst_n,
    input logic                      wb_cyc,
    input logic                      wb_stb,
    input logic                      wb_we,
    input logic                      wb_ack,
    input logic [ADDR_WIDTH-1:0]     wb_adr,
    input logic [31:0]               wb_dat_w,
    input logic                      halt,
    input cpu_types_pkg::seq_state_t state
);

    a_stb_needs_cyc: assert property (@(posedge CLK) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request held until the slave acknowledges
    a_request_stable: assert property (@(posedge CLK) disable iff (!arst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && (!wb_we || $stable(wb_dat_w)))
        else $error("bus request changed before wb_ack");

    a_halt_sticky: assert property (@(posedge CLK) disable iff (!arst_n)
        halt |=> halt && !wb_cyc && (state == cpu_types_pkg::HALTED))
        else $error("bus activity or halt dropped after halting");

    a_idle_after_reset: assert property (@(posedge CLK) $rose(arst_n) |-> !wb_cyc && !wb_stb)
        else $error("bus cycle started in the first cycle after reset");

endmodule

bind core_datapath mips_core_properties #(
    .ADDR_WIDTH (ADDR_WIDTH)
) u_mips_core_properties (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_ack   (wb_ack),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .halt     (halt),
    .state    (state)
);

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam logic [31:0] RESET_PC   = 32'h100;
    localparam int          ADDR_WIDTH = 16;
    localparam int          MEM_WORDS  = 1024;
    localparam logic [31:0] SEED       = 32'd25050;
    localparam logic [31:0] DATA_BASE  = 32'h800;

    logic                  CLK;
    logic                  arst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic                  halt;
    logic [ADDR_WIDTH-1:0] wb_adr;
    logic [31:0]           wb_dat_w;
    logic [31:0]           wb_dat_r = '0;
    logic                  wb_ack   = 1'b0;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];
    // expected reads hold fetches and loads in bus order
    logic [31:0] exp_rd [$];
    logic [31:0] exp_st_adr [$];
    logic [31:0] exp_st_dat [$];
    int          rd_idx = 0;
    int          st_idx = 0;
    int          wr_ptr;
    int          st_off;
    logic [1:0]  wait_left;
    logic [31:0] wait_rnd = SEED;

    clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) u_clock_gen (.CLK(CLK), .arst_n(arst_n));

    mips_core #(.RESET_PC(RESET_PC), .ADDR_WIDTH(ADDR_WIDTH)) u_mips_core (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] rtype_word(input cpu_types_pkg::funct_t f,
                                               input int rs, input int rt, input int rd,
                                               input int sh);
        return {cpu_types_pkg::RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
    endfunction

    function automatic logic [31:0] itype_word(input cpu_types_pkg::opcode_t op,
                                               input int rs, input int rt,
                                               input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[wr_ptr] = word;
        wr_ptr++;
    endtask

    // next result slot at an offset from the base in r5
    task automatic store_reg(input int rt);
        emit(itype_word(cpu_types_pkg::SW, 5, rt, 16'(st_off)));
        st_off += 4;
    endtask

    task automatic build_program();
        cpu_types_pkg::funct_t  rops [12];
        cpu_types_pkg::opcode_t iops [7];
        logic [31:0]            rnd;
        rops = '{cpu_types_pkg::ALU_ADD, cpu_types_pkg::ALU_ADDU, cpu_types_pkg::ALU_SUB,
                 cpu_types_pkg::ALU_SUBU, cpu_types_pkg::ALU_AND, cpu_types_pkg::ALU_OR,
                 cpu_types_pkg::ALU_XOR, cpu_types_pkg::ALU_NOR, cpu_types_pkg::ALU_SLT,
                 cpu_types_pkg::ALU_SLTU, cpu_types_pkg::ALU_SLL, cpu_types_pkg::ALU_SRL};
        iops = '{cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU, cpu_types_pkg::SLTI,
                 cpu_types_pkg::ANDI, cpu_types_pkg::ORI, cpu_types_pkg::XORI,
                 cpu_types_pkg::LUI};
        rnd    = SEED;
        wr_ptr = RESET_PC[11:2];
        st_off = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9E37_79B1) ^ 32'(i);
        end
        // random constants in r1 to r4
        for (int r = 1; r <= 4; r++) begin
            rnd = lcg_next(rnd);
            emit(itype_word(cpu_types_pkg::LUI, 0, r, rnd[31:16]));
            emit(itype_word(cpu_types_pkg::ORI, r, r, rnd[15:0]));
        end
        emit(itype_word(cpu_types_pkg::ORI, 0, 5, DATA_BASE[15:0]));
        foreach (rops[k]) begin
            rnd = lcg_next(rnd);
            emit(rtype_word(rops[k], 1 + k % 4, 1 + (k + 1) % 4, 6, rnd[28:24]));
            store_reg(6);
        end
        // r0 must stay zero
        emit(rtype_word(cpu_types_pkg::ALU_ADD, 1, 2, 0, 0));
        store_reg(0);
        // each immediate op once with bit 15 clear and once with it set
        foreach (iops[k]) begin
            rnd = lcg_next(rnd);
            emit(itype_word(iops[k], 1 + k % 4, 6, {1'b0, rnd[30:16]}));
            store_reg(6);
            emit(itype_word(iops[k], 1 + k % 4, 7, {1'b1, rnd[30:16]}));
            store_reg(7);
        end
        store_reg(1);
        emit(itype_word(cpu_types_pkg::LW, 5, 7, 16'(st_off - 4)));
        store_reg(7);
        // unused opcode executes as a no-op
        emit(32'hC400_0000);
        // beq taken, beq not taken, bne not taken, bne taken
        for (int k = 0; k < 4; k++) begin
            emit(itype_word(k < 2 ? cpu_types_pkg::BEQ : cpu_types_pkg::BNE, 1, 1 + k % 2, 16'd1));
            emit(itype_word(cpu_types_pkg::ADDI, 8, 8, 16'(1 << k)));
        end
        emit({cpu_types_pkg::J, 26'(wr_ptr + 2)});
        emit(itype_word(cpu_types_pkg::ADDI, 8, 8, 16'd16));
        emit({cpu_types_pkg::JAL, 26'(wr_ptr + 2)});
        emit(itype_word(cpu_types_pkg::ADDI, 8, 8, 16'd32));
        store_reg(31);
        emit(itype_word(cpu_types_pkg::ORI, 0, 9, 16'((wr_ptr + 3) * 4)));
        emit(rtype_word(cpu_types_pkg::JR, 9, 0, 0, 0));
        emit(itype_word(cpu_types_pkg::ADDI, 8, 8, 16'd64));
        store_reg(8);
        emit({cpu_types_pkg::HALT, 26'd0});
    endtask

    // instruction-set model without delay slots
    function automatic void run_reference();
        logic [31:0] r [32];
        logic [31:0] pc, ins, a, b, sx, zx, nxt, adr;
        logic [4:0]  rs, rt, rd;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        ref_mem = mem;
        pc = RESET_PC;
        for (int step = 0; step < 4000; step++) begin
            exp_rd.push_back(pc & 32'hFFFF);
            ins = ref_mem[pc[11:2]];
            rs  = ins[25:21];
            rt  = ins[20:16];
            rd  = ins[15:11];
            a   = r[rs];
            b   = r[rt];
            sx  = {{16{ins[15]}}, ins[15:0]};
            zx  = {16'h0000, ins[15:0]};
            nxt = pc + 32'd4;
            case (cpu_types_pkg::opcode_t'(ins[31:26]))
                cpu_types_pkg::RTYPE: begin
                    case (cpu_types_pkg::funct_t'(ins[5:0]))
                        cpu_types_pkg::ALU_ADD, cpu_types_pkg::ALU_ADDU: r[rd] = a + b;
                        cpu_types_pkg::ALU_SUB, cpu_types_pkg::ALU_SUBU: r[rd] = a - b;
                        cpu_types_pkg::ALU_AND:  r[rd] = a & b;
                        cpu_types_pkg::ALU_OR:   r[rd] = a | b;
                        cpu_types_pkg::ALU_XOR:  r[rd] = a ^ b;
                        cpu_types_pkg::ALU_NOR:  r[rd] = ~(a | b);
                        cpu_types_pkg::ALU_SLT:  r[rd] = 32'($signed(a) < $signed(b));
                        cpu_types_pkg::ALU_SLTU: r[rd] = 32'(a < b);
                        cpu_types_pkg::ALU_SLL:  r[rd] = b << ins[10:6];
                        cpu_types_pkg::ALU_SRL:  r[rd] = b >> ins[10:6];
                        cpu_types_pkg::JR:       nxt = a;
                        default: ;
                    endcase
                end
                cpu_types_pkg::J:     nxt = {nxt[31:28], ins[25:0], 2'b00};
                cpu_types_pkg::JAL: begin
                    r[31] = nxt;
                    nxt   = {nxt[31:28], ins[25:0], 2'b00};
                end
                cpu_types_pkg::BEQ:   nxt = (a == b) ? nxt + (sx << 2) : nxt;
                cpu_types_pkg::BNE:   nxt = (a != b) ? nxt + (sx << 2) : nxt;
                cpu_types_pkg::ADDI, cpu_types_pkg::ADDIU: r[rt] = a + sx;
                cpu_types_pkg::SLTI:  r[rt] = 32'($signed(a) < $signed(sx));
                cpu_types_pkg::ANDI:  r[rt] = a & zx;
                cpu_types_pkg::ORI:   r[rt] = a | zx;
                cpu_types_pkg::XORI:  r[rt] = a ^ zx;
                cpu_types_pkg::LUI:   r[rt] = {ins[15:0], 16'h0000};
                cpu_types_pkg::LW: begin
                    adr = a + sx;
                    exp_rd.push_back(adr & 32'hFFFF);
                    r[rt] = ref_mem[adr[11:2]];
                end
                cpu_types_pkg::SW: begin
                    adr = a + sx;
                    exp_st_adr.push_back(adr & 32'hFFFF);
                    exp_st_dat.push_back(b);
                    ref_mem[adr[11:2]] = b;
                end
                cpu_types_pkg::HALT: return;
                default: ;
            endcase
            r[0] = '0;
            pc   = nxt;
        end
    endfunction

    // word-addressed slave with 0 to 3 wait states per cycle
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack    <= 1'b0;
            wait_left <= 2'd1;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[11:2]];
                if (wb_we) begin
                    mem[wb_adr[11:2]] = wb_dat_w;
                end
                wait_rnd  = lcg_next(wait_rnd);
                wait_left <= wait_rnd[29:28];
            end
        end
    end

    // every acknowledged cycle against the next model entry
    always @(posedge CLK) begin
        if (arst_n && wb_cyc && wb_stb && wb_ack) begin
            if (wb_we && st_idx >= exp_st_adr.size()) begin
                abort_run("the core stored more words than the reference model");
            end else if (!wb_we && rd_idx >= exp_rd.size()) begin
                abort_run("the core read more words than the reference model");
            end else if (wb_we) begin
                check_equal("store address", 32'(wb_adr), exp_st_adr[st_idx]);
                check_equal("store data", wb_dat_w, exp_st_dat[st_idx]);
                st_idx++;
            end else begin
                check_equal("read address", 32'(wb_adr), exp_rd[rd_idx]);
                rd_idx++;
            end
        end
    end

    initial begin
        int cycles;
        build_program();
        run_reference();
        cycles = 0;
        do begin
            @(posedge CLK);
            cycles++;
            if (cycles > 20) abort_run("reset was not released within 20 cycles");
        end while (!arst_n);
        check_equal("halt after reset", 32'(halt), 32'd0);
        check_equal("wb_cyc after reset", 32'(wb_cyc), 32'd0);
        check_equal("wb_stb after reset", 32'(wb_stb), 32'd0);
        cycles = 0;
        while (!halt) begin
            @(posedge CLK);
            cycles++;
            if (cycles > 5000) abort_run("halt did not rise within 5000 cycles");
        end
        // quiet bus while halted
        for (int i = 0; i < 50; i++) begin
            @(posedge CLK);
            check_equal("wb_cyc while halted", 32'(wb_cyc), 32'd0);
            check_equal("halt while halted", 32'(halt), 32'd1);
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_equal($sformatf("memory word %0d", i), mem[i], ref_mem[i]);
        end
        if (st_idx == exp_st_adr.size() && rd_idx == exp_rd.size()) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("the core made fewer bus cycles than the reference model");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/cpu_types_pkg.sv
src/control_unit_if.sv
src/control_unit.sv
src/alu.sv
src/register_file.sv
src/core_datapath.sv
src/mips_core.sv
bench/clock_gen.sv
bench/mips_core_properties.sv
bench/mips_core_tb.sv
